//--- vlog.f
common/rx_dsp_pkg.sv
common/rx_regs_pkg.sv
cfo/cfo_nco.sv
cfo/cfo_derotator.sv
hdl/rx_regmap.sv
hdl/rx_frontend.sv
tb/tb_clock.sv
tb/rx_frontend_props.sv
tb/rx_frontend_tb.sv

//--- Bender.yml
package:
  name: rx_frontend

sources:
  - common/rx_dsp_pkg.sv
  - common/rx_regs_pkg.sv
  - cfo/cfo_nco.sv
  - cfo/cfo_derotator.sv
  - hdl/rx_regmap.sv
  - hdl/rx_frontend.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/rx_frontend_props.sv
      - tb/rx_frontend_tb.sv

//--- tb/rx_frontend_tb.sv
`timescale 1ns/10ps

module rx_frontend_tb;

    localparam int TIMEOUT_CYCLES = 50;

    logic                             clk_i;
    logic                             reset_ni;
    rx_dsp_pkg::iq_t                  sample_i;
    logic                             sample_valid_i;
    logic [rx_dsp_pkg::PHASE_W-1:0]   cfo_inc_i;
    logic                             cfo_valid_i;
    logic [rx_regs_pkg::N_ID_2_W-1:0] n_id_2_i;
    logic                             n_id_2_valid_i;
    rx_regs_pkg::reg_req_t            reg_req_i;
    rx_dsp_pkg::iq_t                  sample_o;
    logic                             sample_valid_o;
    rx_regs_pkg::reg_rsp_t            reg_rsp_o;

    // reference model state
    logic [rx_dsp_pkg::PHASE_W-1:0]   model_acc;
    logic [rx_dsp_pkg::PHASE_W-1:0]   model_phase;
    logic                             model_manual;
    rx_dsp_pkg::iq_t                  exp_q[$];
    int                               in_cycle_q[$];
    int                               cycle_cnt    = 0;
    int                               samples_sent = 0;
    int                               acc_expected = 0;

    tb_clock tb_clock_inst (.clk_o(clk_i));

    rx_frontend rx_frontend_inst (.*);

    bind rx_frontend rx_frontend_props props_inst (.*);

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0d ns: %s is 0x%h, expected 0x%h",
                               $time, what, actual, expected));
        end
    endtask

    // sample times e^(j*phase) scaled back by 2^15
    function automatic rx_dsp_pkg::iq_t rotate(input rx_dsp_pkg::iq_t s,
                                               input logic [rx_dsp_pkg::PHASE_W-1:0] phase);
        int              idx;
        longint          c;
        longint          sn;
        rx_dsp_pkg::iq_t r;
        idx  = int'(phase >> (rx_dsp_pkg::PHASE_W - rx_dsp_pkg::LUT_BITS));
        c    = rx_dsp_pkg::COS_LUT[idx];
        sn   = rx_dsp_pkg::COS_LUT[(idx + rx_dsp_pkg::LUT_SIZE - rx_dsp_pkg::SIN_OFFSET)
                                   % rx_dsp_pkg::LUT_SIZE];
        r.re = rx_dsp_pkg::IQ_W'((s.re * c - s.im * sn) >>> (rx_dsp_pkg::TRIG_W - 1));
        r.im = rx_dsp_pkg::IQ_W'((s.re * sn + s.im * c) >>> (rx_dsp_pkg::TRIG_W - 1));
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // model and output monitor
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (!reset_ni) begin
            model_acc    = '0;
            model_phase  = '0;
            model_manual = 1'b0;
        end else begin
            if (sample_valid_i) begin
                exp_q.push_back(rotate(sample_i, model_phase));
                in_cycle_q.push_back(cycle_cnt);
            end
            if (model_manual) begin
                model_acc   = '0;
                model_phase = '0;
            end else begin
                // phase steps by the accumulator as it was before this edge
                if (sample_valid_i) model_phase = model_phase + model_acc;
                if (cfo_valid_i) model_acc = model_acc - cfo_inc_i;
            end
            if (reg_req_i.valid && reg_req_i.we && reg_req_i.addr == rx_regs_pkg::REG_CTRL) begin
                model_manual = reg_req_i.wdata[rx_regs_pkg::CTRL_CFO_MANUAL];
            end
        end
    end

    always @(negedge clk_i) begin
        if (rx_frontend_inst.props_inst.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
        if (sample_valid_o) begin
            if (exp_q.size() == 0) begin
                fail_run("output strobe seen with no sample pending");
            end else begin
                // output is taken at the next rising edge
                check_equal("sample latency", 32'(cycle_cnt + 1 - in_cycle_q.pop_front()),
                            32'(rx_dsp_pkg::DEROT_LATENCY));
                check_equal("sample_o", sample_o, exp_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic drive_cycle(input logic smp_valid, input logic inc_valid, input int inc);
        @(negedge clk_i);
        sample_i       = rx_dsp_pkg::iq_t'($urandom);
        sample_valid_i = smp_valid;
        cfo_inc_i      = rx_dsp_pkg::PHASE_W'(inc);
        cfo_valid_i    = inc_valid;
        if (smp_valid) samples_sent++;
    endtask

    task automatic strobe_n_id_2(input logic [rx_regs_pkg::N_ID_2_W-1:0] value);
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        n_id_2_i       = value;
        n_id_2_valid_i = 1'b1;
        @(negedge clk_i);
        n_id_2_valid_i = 1'b0;
    endtask

    // writes expect zero read data
    task automatic reg_access(input logic write, input rx_regs_pkg::reg_addr_e addr,
                              input logic [31:0] wdata, input logic [31:0] expected);
        int waited;
        waited = 0;
        @(negedge clk_i);
        sample_valid_i  = 1'b0;
        cfo_valid_i     = 1'b0;
        reg_req_i.valid = 1'b1;
        reg_req_i.we    = write;
        reg_req_i.addr  = addr;
        reg_req_i.wdata = wdata;
        do begin
            @(negedge clk_i);
            reg_req_i.valid = 1'b0;
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_run("no register response before the timeout");
        end while (!reg_rsp_o.valid);
        check_equal($sformatf("rdata of address %0d", addr), reg_rsp_o.rdata, expected);
    endtask

    // queue only shrinks on falling edges, so look at it on rising edges
    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        cfo_valid_i    = 1'b0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT_CYCLES) fail_run("expected output samples never arrived");
        end while (exp_q.size() != 0);
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_after_reset();
        reg_access(1'b0, rx_regs_pkg::REG_ID, '0, rx_regs_pkg::RX_ID);
        reg_access(1'b0, rx_regs_pkg::REG_SAMPLE_CNT, '0, 32'd0);
        reg_access(1'b0, rx_regs_pkg::REG_N_ID_2, '0, 32'd0);
        reg_access(1'b0, rx_regs_pkg::REG_CFO_ACC, '0, 32'd0);
        repeat (8) begin
            @(negedge clk_i);
            check_equal("idle sample_valid_o", 32'(sample_valid_o), 32'd0);
        end
    endtask

    task automatic test_manual_mode();
        reg_access(1'b1, rx_regs_pkg::REG_CTRL, 32'd1 << rx_regs_pkg::CTRL_CFO_MANUAL, 32'd0);
        reg_access(1'b0, rx_regs_pkg::REG_CTRL, '0, 32'd1 << rx_regs_pkg::CTRL_CFO_MANUAL);
        drive_cycle(1'b0, 1'b1, 40000);
        repeat (12) drive_cycle(1'b1, 1'b0, 0);
        wait_drained();
        reg_access(1'b0, rx_regs_pkg::REG_CFO_ACC, '0, 32'd0);
    endtask

    task automatic test_cfo_tracking();
        int gap;
        reg_access(1'b1, rx_regs_pkg::REG_CTRL, 32'd0, 32'd0);
        drive_cycle(1'b0, 1'b1, 9000);
        drive_cycle(1'b0, 1'b1, 12345);
        acc_expected = -(9000 + 12345);
        repeat (20) drive_cycle(1'b1, 1'b0, 0);
        repeat (30) begin
            gap = int'($urandom % 4);
            repeat (gap) drive_cycle(1'b0, 1'b0, 0);
            drive_cycle(1'b1, 1'b0, 0);
        end
        wait_drained();
        reg_access(1'b0, rx_regs_pkg::REG_CFO_ACC, '0, 32'(acc_expected));
    endtask

    // large step so old and new accumulator land on different entries
    task automatic test_same_cycle_inc();
        repeat (4) drive_cycle(1'b1, 1'b0, 0);
        drive_cycle(1'b1, 1'b1, 100000);
        acc_expected = acc_expected - 100000;
        repeat (4) drive_cycle(1'b1, 1'b0, 0);
        wait_drained();
        reg_access(1'b0, rx_regs_pkg::REG_CFO_ACC, '0, 32'(acc_expected));
    endtask

    task automatic test_status_regs();
        strobe_n_id_2(2'd2);
        strobe_n_id_2(2'd1);
        strobe_n_id_2(2'd3);
        repeat (7) drive_cycle(1'b1, 1'b0, 0);
        wait_drained();
        reg_access(1'b0, rx_regs_pkg::REG_N_ID_2, '0, 32'd3);
        reg_access(1'b0, rx_regs_pkg::REG_SAMPLE_CNT, '0, 32'(samples_sent));
        reg_access(1'b1, rx_regs_pkg::REG_SAMPLE_CNT, 32'h1234, 32'd0);
        reg_access(1'b0, rx_regs_pkg::REG_SAMPLE_CNT, '0, 32'(samples_sent));
        reg_access(1'b0, rx_regs_pkg::reg_addr_e'(4'd9), '0, 32'd0);
    endtask

    initial begin
        void'($urandom(53));
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        cfo_inc_i      = '0;
        cfo_valid_i    = 1'b0;
        n_id_2_i       = '0;
        n_id_2_valid_i = 1'b0;
        reg_req_i      = '0;
        repeat (16) @(negedge clk_i);
        reset_ni = 1'b1;
        test_after_reset();
        test_manual_mode();
        test_cfo_tracking();
        test_same_cycle_inc();
        test_status_regs();
        if (rx_frontend_inst.props_inst.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

endmodule

//--- tb/rx_frontend_props.sv
`timescale 1ns/10ps

module rx_frontend_props (
    input logic                  clk_i,
    input logic                  reset_ni,
    input logic                  sample_valid_i,
    input logic                  sample_valid_o,
    input rx_regs_pkg::reg_req_t reg_req_i,
    input rx_regs_pkg::reg_rsp_t reg_rsp_o
);

    // count of failed assertions
    int fail_count = 0;

    // output strobe exactly DEROT_LATENCY cycles after each input strobe
    sample_latency_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        sample_valid_o == $past(sample_valid_i, rx_dsp_pkg::DEROT_LATENCY))
        else begin
            $error("sample_valid_o does not follow sample_valid_i by the pipeline latency");
            fail_count++;
        end

    rsp_latency_a: assert property (@(posedge clk_i) disable iff (!reset_ni)
        reg_rsp_o.valid == $past(reg_req_i.valid))
        else begin
            $error("register response valid does not follow request valid by one cycle");
            fail_count++;
        end

    reset_quiet_a: assert property (@(posedge clk_i)
        !reset_ni |=> !sample_valid_o && !reg_rsp_o.valid)
        else begin
            $error("valid output high during reset");
            fail_count++;
        end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // 40 ns period
    always #20 clk_o = ~clk_o;

endmodule

//--- hdl/rx_frontend.sv
`timescale 1ns/10ps

module rx_frontend (
    input  logic                                clk_i,
    input  logic                                reset_ni,

    input  rx_dsp_pkg::iq_t                     sample_i,
    input  logic                                sample_valid_i,
    input  logic [rx_dsp_pkg::PHASE_W-1:0]      cfo_inc_i,
    input  logic                                cfo_valid_i,
    input  logic [rx_regs_pkg::N_ID_2_W-1:0]    n_id_2_i,
    input  logic                                n_id_2_valid_i,
    input  rx_regs_pkg::reg_req_t               reg_req_i,

    output rx_dsp_pkg::iq_t                     sample_o,
    output logic                                sample_valid_o,
    output rx_regs_pkg::reg_rsp_t               reg_rsp_o
);

    logic                              cfo_manual;
    rx_dsp_pkg::trig_t                 trig;
    logic                              trig_valid;
    logic [rx_dsp_pkg::PHASE_W-1:0]    cfo_acc;

    cfo_nco cfo_nco_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .cfo_manual_i   (cfo_manual),
        .trig_o         (trig),
        .trig_valid_o   (trig_valid),
        .cfo_acc_o      (cfo_acc)
    );

    cfo_derotator cfo_derotator_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .trig_i         (trig),
        .trig_valid_i   (trig_valid),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o)
    );

    rx_regmap rx_regmap_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .reg_req_i      (reg_req_i),
        .reg_rsp_o      (reg_rsp_o),
        .sample_valid_i (sample_valid_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .cfo_acc_i      (cfo_acc),
        .cfo_manual_o   (cfo_manual)
    );

endmodule

//--- hdl/rx_regmap.sv
`timescale 1ns/10ps

module rx_regmap (
    input  logic                                clk_i,
    input  logic                                reset_ni,

    input  rx_regs_pkg::reg_req_t               reg_req_i,
    output rx_regs_pkg::reg_rsp_t               reg_rsp_o,

    input  logic                                sample_valid_i,
    input  logic [rx_regs_pkg::N_ID_2_W-1:0]    n_id_2_i,
    input  logic                                n_id_2_valid_i,
    input  logic [rx_dsp_pkg::PHASE_W-1:0]      cfo_acc_i,
    output logic                                cfo_manual_o
);

    logic                                ctrl_cfo_manual;
    logic [rx_regs_pkg::REG_DW-1:0]      sample_cnt;
    logic [rx_regs_pkg::N_ID_2_W-1:0]    n_id_2;
    logic [rx_regs_pkg::REG_DW-1:0]      rdata;
    logic                                ctrl_we;

    assign ctrl_we = reg_req_i.valid && reg_req_i.we &&
                     (reg_req_i.addr == rx_regs_pkg::REG_CTRL);

    // ----------------------------------------------------------------------
    // control and status state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ctrl_cfo_manual <= 1'b0;
            sample_cnt      <= '0;
            n_id_2          <= '0;
        end else begin
            if (ctrl_we) begin
                ctrl_cfo_manual <= reg_req_i.wdata[rx_regs_pkg::CTRL_CFO_MANUAL];
            end
            // wraps at 2^32
            if (sample_valid_i) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            if (n_id_2_valid_i) begin
                n_id_2 <= n_id_2_i;
            end
        end
    end

    // ----------------------------------------------------------------------
    // read decode
    // ----------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        case (reg_req_i.addr)
            rx_regs_pkg::REG_ID:         rdata = rx_regs_pkg::RX_ID;
            rx_regs_pkg::REG_CTRL:       rdata[rx_regs_pkg::CTRL_CFO_MANUAL] = ctrl_cfo_manual;
            rx_regs_pkg::REG_SAMPLE_CNT: rdata = sample_cnt;
            rx_regs_pkg::REG_N_ID_2:     rdata[rx_regs_pkg::N_ID_2_W-1:0] = n_id_2;
            rx_regs_pkg::REG_CFO_ACC: begin
                rdata = {{(rx_regs_pkg::REG_DW - rx_dsp_pkg::PHASE_W){cfo_acc_i[rx_dsp_pkg::PHASE_W-1]}},
                         cfo_acc_i};
            end
            default:                     rdata = '0;
        endcase
        // writes answer with zero
        if (reg_req_i.we) begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reg_rsp_o.valid <= 1'b0;
        end else begin
            reg_rsp_o.valid <= reg_req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reg_req_i.valid) begin
            reg_rsp_o.rdata <= rdata;
        end
    end

    assign cfo_manual_o = ctrl_cfo_manual;

endmodule

//--- cfo/cfo_derotator.sv
`timescale 1ns/10ps

module cfo_derotator (
    input  logic                clk_i,
    input  logic                reset_ni,

    input  rx_dsp_pkg::iq_t     sample_i,
    input  logic                sample_valid_i,
    input  rx_dsp_pkg::trig_t   trig_i,
    input  logic                trig_valid_i,

    output rx_dsp_pkg::iq_t     sample_o,
    output logic                sample_valid_o
);

    rx_dsp_pkg::iq_t                      sample_d;
    logic signed [rx_dsp_pkg::MULT_W-1:0] re_sum;
    logic signed [rx_dsp_pkg::MULT_W-1:0] im_sum;
    logic signed [rx_dsp_pkg::MULT_W-1:0] re_shift;
    logic signed [rx_dsp_pkg::MULT_W-1:0] im_shift;
    logic                                 sum_valid;

    // line the sample up with the lookup output
    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_d <= sample_i;
        end
    end

    // ----------------------------------------------------------------------
    // stage one, full width products
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (trig_valid_i) begin
            re_sum <= sample_d.re * trig_i.cos - sample_d.im * trig_i.sin;
            im_sum <= sample_d.re * trig_i.sin + sample_d.im * trig_i.cos;
        end
    end

    // ----------------------------------------------------------------------
    // stage two, scale back to sample width
    // ----------------------------------------------------------------------
    assign re_shift = re_sum >>> (rx_dsp_pkg::TRIG_W - 1);
    assign im_shift = im_sum >>> (rx_dsp_pkg::TRIG_W - 1);

    always_ff @(posedge clk_i) begin
        if (sum_valid) begin
            sample_o.re <= re_shift[rx_dsp_pkg::IQ_W-1:0];
            sample_o.im <= im_shift[rx_dsp_pkg::IQ_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_valid      <= 1'b0;
            sample_valid_o <= 1'b0;
        end else begin
            sum_valid      <= trig_valid_i;
            sample_valid_o <= sum_valid;
        end
    end

endmodule

//--- cfo/cfo_nco.sv
`timescale 1ns/10ps

module cfo_nco (
    input  logic                             clk_i,
    input  logic                             reset_ni,

    input  logic                             sample_valid_i,
    input  logic [rx_dsp_pkg::PHASE_W-1:0]   cfo_inc_i,
    input  logic                             cfo_valid_i,
    input  logic                             cfo_manual_i,

    output rx_dsp_pkg::trig_t                trig_o,
    output logic                             trig_valid_o,
    output logic [rx_dsp_pkg::PHASE_W-1:0]   cfo_acc_o
);

    logic [rx_dsp_pkg::PHASE_W-1:0]  cfo_acc;
    logic [rx_dsp_pkg::PHASE_W-1:0]  phase;
    logic [rx_dsp_pkg::LUT_BITS-1:0] cos_idx;
    logic [rx_dsp_pkg::LUT_BITS-1:0] sin_idx;

    // ----------------------------------------------------------------------
    // accumulator and phase
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_acc      <= '0;
            phase        <= '0;
            trig_valid_o <= 1'b0;
        end else begin
            trig_valid_o <= sample_valid_i;
            if (cfo_manual_i) begin
                // manual mode, no correction
                cfo_acc <= '0;
                phase   <= '0;
            end else begin
                // detector increments are relative to the last one
                if (cfo_valid_i) begin
                    cfo_acc <= cfo_acc - cfo_inc_i;
                end
                // old accumulator value is used on a shared cycle
                if (sample_valid_i) begin
                    phase <= phase + cfo_acc;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // sine/cosine lookup
    // ----------------------------------------------------------------------
    assign cos_idx = phase[rx_dsp_pkg::PHASE_W-1 -: rx_dsp_pkg::LUT_BITS];

    // sin(x) = cos(x - pi/2), index wraps on its own
    assign sin_idx = cos_idx - rx_dsp_pkg::LUT_BITS'(rx_dsp_pkg::SIN_OFFSET);

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            trig_o.cos <= rx_dsp_pkg::COS_LUT[cos_idx];
            trig_o.sin <= rx_dsp_pkg::COS_LUT[sin_idx];
        end
    end

    assign cfo_acc_o = cfo_acc;

endmodule

//--- common/rx_regs_pkg.sv
package rx_regs_pkg;

    localparam int REG_DW   = 32;
    localparam int N_ID_2_W = 2;

    // status and control register map
    typedef enum logic [3:0] {
        REG_ID         = 4'd0,
        REG_CTRL       = 4'd1,
        REG_SAMPLE_CNT = 4'd2,
        REG_N_ID_2     = 4'd3,
        REG_CFO_ACC    = 4'd4
    } reg_addr_e;

    // CTRL bits
    localparam int CTRL_CFO_MANUAL = 0;

    localparam logic [REG_DW-1:0] RX_ID = 32'h5258_4645;

    typedef struct packed {
        logic              valid;
        logic              we;
        reg_addr_e         addr;
        logic [REG_DW-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic              valid;
        logic [REG_DW-1:0] rdata;
    } reg_rsp_t;

endpackage

//--- common/rx_dsp_pkg.sv
package rx_dsp_pkg;

    // sample and trig widths
    localparam int IQ_W    = 16;
    localparam int TRIG_W  = 16;
    localparam int PHASE_W = 20;

    // full precision of one complex multiplier sum
    localparam int MULT_W = IQ_W + TRIG_W + 1;

    // lookup addressed by the top phase bits
    localparam int LUT_BITS   = 6;
    localparam int LUT_SIZE   = 2 ** LUT_BITS;
    localparam int SIN_OFFSET = LUT_SIZE / 4;

    // sample strobe in to sample strobe out
    localparam int DEROT_LATENCY = 3;

    typedef struct packed {
        logic signed [IQ_W-1:0] re;
        logic signed [IQ_W-1:0] im;
    } iq_t;

    typedef struct packed {
        logic signed [TRIG_W-1:0] cos;
        logic signed [TRIG_W-1:0] sin;
    } trig_t;

    // one full turn of cosine, scaled by 32767
    localparam logic signed [TRIG_W-1:0] COS_LUT [LUT_SIZE] = '{
         32767,  32609,  32137,  31356,  30273,  28898,  27245,  25329,
         23170,  20787,  18204,  15446,  12539,   9512,   6393,   3212,
             0,  -3212,  -6393,  -9512, -12539, -15446, -18204, -20787,
        -23170, -25329, -27245, -28898, -30273, -31356, -32137, -32609,
        -32767, -32609, -32137, -31356, -30273, -28898, -27245, -25329,
        -23170, -20787, -18204, -15446, -12539,  -9512,  -6393,  -3212,
             0,   3212,   6393,   9512,  12539,  15446,  18204,  20787,
         23170,  25329,  27245,  28898,  30273,  31356,  32137,  32609
    };

endpackage
